// ==== design/dac_ctrl_pkg.sv ====
// DAC chain control package
// command word encoding, frame layout and shared constants for the SPI DAC chain

package dac_ctrl_pkg;

    // ----------------------------------------------------------------------
    // chain geometry and DAC command set
    // ----------------------------------------------------------------------
    localparam int NUM_CHANNELS = 4;                   // daisy-chained DACs
    localparam int WORD_BITS    = 32;                  // bits per DAC command word
    localparam int FRAME_BITS   = NUM_CHANNELS * WORD_BITS; // bits per SPI transaction

    localparam logic [3:0]  DAC_CMD_WRU  = 4'h3;       // write and update
    localparam logic [3:0]  DAC_CMD_NOP  = 4'hF;       // no operation
    localparam logic [15:0] DAC_VAL_INIT = 16'h8000;   // mid-scale, zero current

    // ----------------------------------------------------------------------
    // buffering and SPI timing
    // ----------------------------------------------------------------------
    localparam int BUF_DEPTH   = 2;                    // frames held, also initial credits
    localparam int SCLK_HALF   = 2;                    // sysclk cycles per sclk half period

    localparam int DEPTH_CNT_W = $clog2(BUF_DEPTH + 1); // holds 0..BUF_DEPTH
    localparam int PTR_W       = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CH_W        = $clog2(NUM_CHANNELS); // channel index width
    localparam int BIT_CNT_W   = $clog2(FRAME_BITS);   // serializer bit counter
    localparam int DIV_W       = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

    // serializer FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;           // waiting for a frame
    localparam logic [1:0] ST_SHIFT  = 2'd1;           // clocking bits out
    localparam logic [1:0] ST_FINISH = 2'd2;           // csel hold after last bit

    // one DAC command word, seen as fields or as a raw SPI word
    typedef union packed {
        struct packed {
            logic [7:0]  pad;                          // always zero
            logic [3:0]  cmd;                          // DAC command code
            logic [3:0]  addr;                         // always zero
            logic [15:0] value;                        // DAC output code
        } fields;
        logic [WORD_BITS-1:0] raw;
    } dac_word_t;

    // channel 4 sits at the top so it is shifted first, reaching the far DAC
    typedef struct packed {
        dac_word_t [NUM_CHANNELS-1:0] ch;              // ch[0] is channel 1
    } dac_frame_t;

endpackage

// ==== design/dac_cmd_builder.sv ====
// DAC command builder
// catches val_ready rising edges, encodes one command word per channel and
// pushes the frame into the buffer while credits remain

`timescale 1ns/1ps

module dac_cmd_builder
    import dac_ctrl_pkg::*;
(
    input  logic                          sysclk,     // system clock
    input  logic                          rst,        // sync reset, active high
    input  logic                          val_ready,  // controller values are ready
    input  logic [NUM_CHANNELS-1:0][15:0] cont_val,   // controller outputs, [0] is ch1
    input  logic [NUM_CHANNELS-1:0]       ch_en,      // per channel write enable
    input  logic                          credit_ret, // buffer freed one slot
    output logic                          push,       // frame write strobe
    output dac_frame_t                    frame       // encoded command frame
);

    logic                          vr_now;            // val_ready sampled
    logic                          vr_last;           // previous sample
    logic                          val_edge;          // rising edge seen
    logic [NUM_CHANNELS-1:0][15:0] val_q;             // values captured at the edge
    logic [NUM_CHANNELS-1:0]       en_q;              // enables captured at the edge
    logic [DEPTH_CNT_W-1:0]        credits;           // free buffer slots

    // ----------------------------------------------------------------------
    // edge detect and value capture
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            vr_now  <= 1'b0;
            vr_last <= 1'b0;
        end else begin
            vr_now  <= val_ready;
            vr_last <= vr_now;
        end
    end

    // grab the inputs as val_ready first reads high
    always_ff @(posedge sysclk) begin
        if (val_ready && !vr_now) begin
            val_q <= cont_val;
            en_q  <= ch_en;
        end
    end

    assign val_edge = vr_now && !vr_last;
    assign push     = val_edge && (credits != '0);   // no credit means the edge is dropped

    // ----------------------------------------------------------------------
    // credit counter
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            credits <= DEPTH_CNT_W'(BUF_DEPTH);       // buffer starts empty
        end else begin
            case ({push, credit_ret})
                2'b10:   credits <= credits - 1'b1;   // spent on push
                2'b01:   credits <= credits + 1'b1;   // returned by buffer
                default: credits <= credits;          // both or neither
            endcase
        end
    end

    // word encoding, disabled channels get a no-op at mid-scale
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            frame.ch[i].fields.pad   = 8'h00;
            frame.ch[i].fields.cmd   = en_q[i] ? DAC_CMD_WRU : DAC_CMD_NOP;
            frame.ch[i].fields.addr  = 4'h0;
            frame.ch[i].fields.value = en_q[i] ? val_q[i] : DAC_VAL_INIT;
        end
    end

endmodule

// ==== design/dac_frame_buffer.sv ====
// DAC frame buffer
// two-frame FIFO between builder and serializer, returns a credit per pop
// and keeps the last accepted frame for register readback

`timescale 1ns/1ps

module dac_frame_buffer
    import dac_ctrl_pkg::*;
(
    input  logic        sysclk,       // system clock
    input  logic        rst,          // sync reset, active high
    input  logic        push,         // builder writes a frame
    input  dac_frame_t  frame_in,     // frame from builder
    output logic        credit_ret,   // one slot freed
    output logic        frame_valid,  // head frame available
    output dac_frame_t  frame_out,    // head frame to serializer
    input  logic        frame_pop,    // serializer takes the head
    input  logic [15:0] reg_raddr,    // readback address
    output logic [31:0] reg_rdata     // readback data
);

    dac_frame_t             mem [BUF_DEPTH];  // frame storage
    logic [PTR_W-1:0]       wr_ptr;           // next slot to write
    logic [PTR_W-1:0]       rd_ptr;           // head slot
    logic [DEPTH_CNT_W-1:0] count;            // frames held
    dac_frame_t             last_frame;       // most recent accepted frame
    logic [CH_W-1:0]        rd_idx;           // channel index from address
    logic                   rd_hit;           // address selects a channel

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // FIFO storage and pointers
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (push) begin
            mem[wr_ptr] <= frame_in;  // credits keep this from overflowing
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (frame_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, frame_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // push and pop cancel
            endcase
            credit_ret <= frame_pop;          // slot is free next cycle
        end
    end

    assign frame_valid = (count != '0);
    assign frame_out   = mem[rd_ptr];

    // ----------------------------------------------------------------------
    // readback of the last accepted frame
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            last_frame <= '0;                 // reads zero until first frame
        end else if (push) begin
            last_frame <= frame_in;
        end
    end

    // channel n lives at address bits 7..4 == n
    assign rd_hit = (reg_raddr[7:4] != 4'd0) && (reg_raddr[7:4] <= 4'(NUM_CHANNELS));
    assign rd_idx = CH_W'(reg_raddr[7:4] - 4'd1);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_hit ? last_frame.ch[rd_idx].raw : '0;
        end
    end

endmodule

// ==== design/dac_spi_chain.sv ====
// SPI serializer for the DAC chain
// pops one frame at a time and shifts it out MSB first as a single
// 128-bit transaction framed by csel

`timescale 1ns/1ps

module dac_spi_chain
    import dac_ctrl_pkg::*;
(
    input  logic       sysclk,       // system clock
    input  logic       rst,          // sync reset, active high
    input  logic       frame_valid,  // buffer has a frame
    input  dac_frame_t frame_in,     // head frame from buffer
    output logic       frame_pop,    // take the head frame
    output logic       sclk,         // serial clock
    output logic       mosi,         // serial data out
    output logic       csel          // chip select, active low
);

    logic [1:0]            state;      // FSM state
    logic [DIV_W-1:0]      div_cnt;    // sclk half period divider
    logic [BIT_CNT_W-1:0]  bit_cnt;    // bits already sent
    logic [FRAME_BITS-1:0] shreg;      // outgoing bits, current bit at top
    logic [FRAME_BITS-1:0] load_bits;  // frame flattened to SPI order
    logic                  half_done;  // divider at end of half period
    logic                  fall;       // sclk falls on this edge
    logic                  last_bit;   // bit on mosi is the final one

    // ----------------------------------------------------------------------
    // frame flattening and handshake
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            load_bits[i*WORD_BITS +: WORD_BITS] = frame_in.ch[i].raw;  // ch4 ends up at MSB
        end
    end

    assign frame_pop = (state == ST_IDLE) && frame_valid;  // pop as soon as idle
    assign half_done = (div_cnt == DIV_W'(SCLK_HALF - 1));
    assign fall      = (state == ST_SHIFT) && half_done && sclk;
    assign last_bit  = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // shift register, loaded on pop and advanced on each falling edge
    always_ff @(posedge sysclk) begin
        if (frame_pop) begin
            shreg <= load_bits;
        end else if (fall) begin
            shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
        end
    end

    // ----------------------------------------------------------------------
    // control FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state   <= ST_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            csel    <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_pop) begin
                        state   <= ST_SHIFT;
                        csel    <= 1'b0;                        // start of transaction
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        mosi    <= load_bits[FRAME_BITS-1];     // first bit before first rise
                    end
                end
                ST_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        if (sclk) begin                         // falling edge, next bit
                            if (last_bit) begin
                                state <= ST_FINISH;
                                mosi  <= 1'b0;                  // park data line low
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                mosi    <= shreg[FRAME_BITS-2];
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                ST_FINISH: begin
                    if (csel) begin
                        state <= ST_IDLE;                       // one cycle after csel rise
                    end else if (half_done) begin
                        csel <= 1'b1;                           // half period after last fall
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/dac_ctrl_top.sv ====
// DAC chain controller top level
// builder, two-frame buffer and SPI serializer for four chained DACs

`timescale 1ns/1ps

module dac_ctrl_top
    import dac_ctrl_pkg::*;
(
    input  logic                          sysclk,     // system clock
    input  logic                          rst,        // sync reset, active high
    input  logic [NUM_CHANNELS-1:0][15:0] cont_val,   // controller outputs, [0] is ch1
    input  logic [NUM_CHANNELS-1:0]       ch_en,      // per channel write enable
    input  logic                          val_ready,  // new controller values
    input  logic [15:0]                   reg_raddr,  // readback address
    output logic [31:0]                   reg_rdata,  // readback data
    output logic                          sclk,       // serial clock
    output logic                          mosi,       // serial data out
    output logic                          csel        // chip select, active low
);

    // ----------------------------------------------------------------------
    // internal links
    // ----------------------------------------------------------------------
    logic       push;         // builder to buffer strobe
    dac_frame_t build_frame;  // encoded frame from builder
    logic       credit_ret;   // buffer slot freed
    logic       frame_valid;  // buffer head available
    dac_frame_t head_frame;   // buffer head to serializer
    logic       frame_pop;    // serializer takes head

    dac_cmd_builder dac_cmd_builder_inst (
        .sysclk     (sysclk),
        .rst        (rst),
        .val_ready  (val_ready),
        .cont_val   (cont_val),
        .ch_en      (ch_en),
        .credit_ret (credit_ret),
        .push       (push),
        .frame      (build_frame)
    );

    dac_frame_buffer dac_frame_buffer_inst (
        .sysclk      (sysclk),
        .rst         (rst),
        .push        (push),
        .frame_in    (build_frame),
        .credit_ret  (credit_ret),
        .frame_valid (frame_valid),
        .frame_out   (head_frame),
        .frame_pop   (frame_pop),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata)
    );

    // serializer drains the buffer one transaction at a time
    dac_spi_chain dac_spi_chain_inst (
        .sysclk      (sysclk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame_in    (head_frame),
        .frame_pop   (frame_pop),
        .sclk        (sclk),
        .mosi        (mosi),
        .csel        (csel)
    );

endmodule

// ==== bench/dac_ctrl_tb.sv ====
// DAC chain controller testbench
// drives controller values, decodes the SPI chain and checks frames and readback

`timescale 1ns/1ps

module dac_ctrl_tb
    import dac_ctrl_pkg::*;
();

    logic                          sysclk;
    logic                          rst;
    logic [NUM_CHANNELS-1:0][15:0] cont_val;
    logic [NUM_CHANNELS-1:0]       ch_en;
    logic                          val_ready;
    logic [15:0]                   reg_raddr;
    logic [31:0]                   reg_rdata;
    logic                          sclk;
    logic                          mosi;
    logic                          csel;

    logic [FRAME_BITS-1:0] exp_q[$];          // frames the DUT must send in order
    logic [FRAME_BITS-1:0] obs_q[$];          // frames seen on the SPI lines
    int                    low_q[$];          // sysclk cycles csel stayed low
    int                    rise_q[$];         // sclk rises per transaction
    logic [FRAME_BITS-1:0] last_exp;          // last frame the builder should accept
    logic [FRAME_BITS-1:0] mon_bits;
    logic [FRAME_BITS-1:0] got;
    logic [FRAME_BITS-1:0] want;
    logic                  mon_active;
    logic                  sclk_prev;
    int                    mon_low;
    int                    mon_rise;
    int                    got_low;
    int                    got_rise;
    int                    n_seen;            // transactions compared so far
    int                    errors;
    int                    test_base;
    int                    tests_run;
    int                    tests_failed;
    logic [31:0]           seed;

    dac_ctrl_top dac_ctrl_top_inst (
        .sysclk    (sysclk),
        .rst       (rst),
        .cont_val  (cont_val),
        .ch_en     (ch_en),
        .val_ready (val_ready),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .sclk      (sclk),
        .mosi      (mosi),
        .csel      (csel)
    );

    always #50 sysclk = ~sysclk;              // 100 ns period

    // ----------------------------------------------------------------------
    // reference model and random source
    // ----------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;  // plain LCG step
        return seed;
    endfunction

    // channel 1 at the bottom and channel 4 on top so it leaves first
    function automatic logic [FRAME_BITS-1:0] expected_frame(
        input logic [NUM_CHANNELS-1:0][15:0] vals,
        input logic [NUM_CHANNELS-1:0]       en
    );
        logic [FRAME_BITS-1:0] f;
        f = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (en[i])
                f[32*i +: 32] = {8'h00, DAC_CMD_WRU, 4'h0, vals[i]};
            else
                f[32*i +: 32] = {8'h00, DAC_CMD_NOP, 4'h0, DAC_VAL_INIT};  // hold mid-scale
        end
        return f;
    endfunction

    // ----------------------------------------------------------------------
    // SPI monitor and compare
    // ----------------------------------------------------------------------
    always @(negedge sysclk) begin
        if (rst) begin
            mon_active = 1'b0;
            sclk_prev  = 1'b0;
        end else begin
            if (!csel) begin
                if (!mon_active) begin            // new transaction
                    mon_active = 1'b1;
                    mon_bits   = '0;
                    mon_low    = 0;
                    mon_rise   = 0;
                end
                mon_low++;
                if (sclk && !sclk_prev) begin     // data is stable around the rise
                    mon_bits = {mon_bits[FRAME_BITS-2:0], mosi};
                    mon_rise++;
                end
            end else if (mon_active) begin
                mon_active = 1'b0;
                obs_q.push_back(mon_bits);
                low_q.push_back(mon_low);
                rise_q.push_back(mon_rise);
            end
            sclk_prev = sclk;
        end
    end

    always @(posedge sysclk) begin
        if (obs_q.size() > 0) begin
            got      = obs_q.pop_front();
            got_low  = low_q.pop_front();
            got_rise = rise_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("unexpected SPI transaction at %0t carrying %h", $time, got);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (got !== want) begin
                    $display("[ERROR] %0t mosi frame: expected %h, got %h", $time, want, got);
                    errors++;
                end
                if (got_rise != FRAME_BITS) begin
                    $display("[ERROR] %0t sclk periods: expected %0d, got %0d",
                             $time, FRAME_BITS, got_rise);
                    errors++;
                end
                // 128 full periods starting low, then a half period tail
                if (got_low != 2 * SCLK_HALF * FRAME_BITS + SCLK_HALF) begin
                    $display("[ERROR] %0t csel low cycles: expected %0d, got %0d", $time,
                             2 * SCLK_HALF * FRAME_BITS + SCLK_HALF, got_low);
                    errors++;
                end
            end
            n_seen++;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic random_values(output logic [NUM_CHANNELS-1:0][15:0] vals);
        logic [31:0] r;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            r       = next_rand();
            vals[i] = r[31:16];                   // upper bits are the better ones
        end
    endtask

    task automatic send_edge(input logic [NUM_CHANNELS-1:0][15:0] vals,
                             input logic [NUM_CHANNELS-1:0] en, input bit accept);
        @(negedge sysclk);
        cont_val  = vals;
        ch_en     = en;
        val_ready = 1'b1;
        if (accept) begin
            last_exp = expected_frame(vals, en);
            exp_q.push_back(last_exp);
        end
        @(negedge sysclk);
        val_ready = 1'b0;
    endtask

    task automatic wait_seen(input int target, input int limit, input string what);
        int cyc;
        cyc = 0;
        while (n_seen < target && cyc < limit) begin
            @(negedge sysclk);
            cyc++;
        end
        if (n_seen < target) begin
            $display("timeout: %s not seen on SPI within %0d cycles", what, limit);
            errors++;
        end
    endtask

    task automatic check_reg(input logic [15:0] addr, input logic [31:0] exp_data);
        @(negedge sysclk);
        reg_raddr = addr;
        @(negedge sysclk);                        // registered read takes one cycle
        if (reg_rdata !== exp_data) begin
            $display("[ERROR] %0t reg_rdata @%h: expected %h, got %h",
                     $time, addr, exp_data, reg_rdata);
            errors++;
        end
    endtask

    task automatic check_readback();
        for (int n = 1; n <= NUM_CHANNELS; n++) begin
            check_reg(16'(n << 4), last_exp[32*(n-1) +: 32]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - test_base);
        end
        test_base = errors;
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [NUM_CHANNELS-1:0][15:0] vals;
        logic [31:0]                   r;
        int                            seen_base;
        sysclk       = 1'b0;
        rst          = 1'b1;
        cont_val     = '0;
        ch_en        = '0;
        val_ready    = 1'b0;
        reg_raddr    = '0;
        last_exp     = '0;
        n_seen       = 0;
        errors       = 0;
        test_base    = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'ha72c;
        repeat (5) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;

        @(negedge sysclk);
        if (csel !== 1'b1) begin
            $display("[ERROR] %0t csel: expected 1, got %b", $time, csel);
            errors++;
        end
        if (sclk !== 1'b0) begin
            $display("[ERROR] %0t sclk: expected 0, got %b", $time, sclk);
            errors++;
        end
        check_readback();                         // nothing accepted yet so all read zero
        end_test("reset state");

        random_values(vals);
        send_edge(vals, 4'hF, 1'b1);
        wait_seen(1, 2000, "all-enabled frame");
        end_test("single frame, all channels enabled");

        random_values(vals);
        r = next_rand();
        if (r[7:4] == 4'hF)
            r[7:4] = 4'b1010;                     // keep at least one channel off
        send_edge(vals, r[7:4], 1'b1);
        wait_seen(2, 2000, "partial-enable frame");
        end_test("partial enables");

        check_readback();
        check_reg(16'h0050, 32'h0);               // channel 5 does not exist
        check_reg(16'h0000, 32'h0);
        end_test("register readback");

        seen_base = n_seen;
        for (int k = 0; k < 4; k++) begin
            random_values(vals);
            send_edge(vals, 4'hF, k < 3);         // fourth edge finds no credit
            repeat (2) @(negedge sysclk);
        end
        check_readback();                         // still the third frame
        wait_seen(seen_base + 3, 4000, "burst frames");
        repeat (1500) @(negedge sysclk);
        if (n_seen != seen_base + 3) begin
            $display("dropped burst frame was sent anyway, %0d transactions seen",
                     n_seen - seen_base);
            errors++;
        end
        end_test("burst with back-pressure");

        random_values(vals);
        r = next_rand();
        send_edge(vals, r[11:8], 1'b1);
        wait_seen(seen_base + 4, 2000, "frame after burst");
        check_readback();
        end_test("credits returned after burst");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== dac_ctrl.f ====
design/dac_ctrl_pkg.sv
design/dac_cmd_builder.sv
design/dac_frame_buffer.sv
design/dac_spi_chain.sv
design/dac_ctrl_top.sv
bench/dac_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the DAC chain testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module dac_ctrl_tb -f dac_ctrl.f -o dac_ctrl_sim

./obj_dir/dac_ctrl_sim > sim.log
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi
